/* verilog/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = $clog2(DATA_W);
    localparam int CLZ_W      = $clog2(DATA_W + 1);

    // credits held by each side after reset.
    localparam int OP_CREDITS  = 4;
    localparam int RES_CREDITS = 4;

    localparam int OP_PTR_W  = $clog2(OP_CREDITS);
    localparam int OP_CNT_W  = $clog2(OP_CREDITS + 1);
    localparam int RES_CNT_W = $clog2(RES_CREDITS + 1);

    typedef enum logic [4:0] {
        EXE_OR_OP    = 5'd0,
        EXE_AND_OP   = 5'd1,
        EXE_XOR_OP   = 5'd2,
        EXE_NOR_OP   = 5'd3,
        EXE_SLL_OP   = 5'd4,
        EXE_SRL_OP   = 5'd5,
        EXE_SRA_OP   = 5'd6,
        EXE_ADD_OP   = 5'd7,
        EXE_ADDU_OP  = 5'd8,
        EXE_SUB_OP   = 5'd9,
        EXE_SUBU_OP  = 5'd10,
        EXE_SLT_OP   = 5'd11,
        EXE_SLTU_OP  = 5'd12,
        EXE_CLZ_OP   = 5'd13,
        EXE_CLO_OP   = 5'd14,
        EXE_MFHI_OP  = 5'd15,
        EXE_MFLO_OP  = 5'd16,
        EXE_MTHI_OP  = 5'd17,
        EXE_MTLO_OP  = 5'd18,
        EXE_MULT_OP  = 5'd19,
        EXE_MULTU_OP = 5'd20,
        EXE_MUL_OP   = 5'd21
    } aluop_t;

    typedef struct packed {
        aluop_t                  aluop;
        logic [DATA_W-1:0]       reg1;
        logic [DATA_W-1:0]       reg2;
        logic [REG_ADDR_W-1:0]   wd;
        logic                    wreg;
    } ex_op_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]   wd;
        logic                    wreg;
        logic [DATA_W-1:0]       wdata;
    } ex_res_t;

    typedef struct packed {
        logic [DATA_W-1:0]       hi;
        logic [DATA_W-1:0]       lo;
    } hilo_t;

endpackage

`default_nettype wire

/* verilog/op_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module op_queue
    import ex_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  logic    push_i,
    input  ex_op_t  op_i,
    input  logic    pop_i,
    output ex_op_t  head_o,
    output logic    head_valid_o,
    output logic    credit_o
);

    ex_op_t                mem [OP_CREDITS];
    logic [OP_PTR_W-1:0]   wr_ptr;
    logic [OP_PTR_W-1:0]   rd_ptr;
    logic [OP_CNT_W-1:0]   fill_cnt;

    // upstream only pushes while it holds a credit, so a push never finds the queue full.
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= op_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
            // every freed slot goes back upstream as one credit.
            credit_o <= pop_i;
        end
    end

    assign head_o       = mem[rd_ptr];
    assign head_valid_o = (fill_cnt != '0);

endmodule

`default_nettype wire

/* verilog/hilo_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module hilo_regs
    import ex_pkg::*;
(
    input  logic   clk,
    input  logic   reset_i,
    input  logic   we_i,
    input  hilo_t  hilo_i,
    output hilo_t  hilo_o
);

    hilo_t hilo_q;

    // the ALU always supplies both halves, keeping the one it does not change.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hilo_q <= '0;
        end else if (we_i) begin
            hilo_q <= hilo_i;
        end
    end

    assign hilo_o = hilo_q;

endmodule

`default_nettype wire

/* verilog/alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_core
    import ex_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  ex_op_t   head_i,
    input  logic     head_valid_i,
    output logic     pop_o,
    input  hilo_t    hilo_i,
    output logic     hilo_we_o,
    output hilo_t    hilo_o,
    input  logic     send_ok_i,
    output logic     res_valid_o,
    output ex_res_t  res_o
);

    logic [DATA_W-1:0]     reg1;
    logic [DATA_W-1:0]     reg2;
    logic                  is_sub;
    logic                  is_signed_mul;
    logic [DATA_W-1:0]     sum;
    logic                  ovf;
    logic                  slt;
    logic [2*DATA_W-1:0]   mul_a;
    logic [2*DATA_W-1:0]   mul_b;
    logic [2*DATA_W-1:0]   product;
    ex_res_t               res_next;
    hilo_t                 hilo_next;
    logic                  hilo_wr;
    ex_res_t               res_q;
    logic                  res_valid_q;

    function automatic logic [CLZ_W-1:0] lead_zeros(input logic [DATA_W-1:0] v);
        logic [CLZ_W-1:0] n;
        n = CLZ_W'(DATA_W);
        for (int i = 0; i < DATA_W; i++) begin
            if (v[i]) begin
                n = CLZ_W'(DATA_W - 1 - i);
            end
        end
        return n;
    endfunction

    assign reg1 = head_i.reg1;
    assign reg2 = head_i.reg2;

    assign is_sub = (head_i.aluop == EXE_SUB_OP) || (head_i.aluop == EXE_SUBU_OP) ||
                    (head_i.aluop == EXE_SLT_OP);
    assign sum    = is_sub ? (reg1 - reg2) : (reg1 + reg2);

    // overflow when the effective operand signs agree but the sum sign differs.
    assign ovf = ~(reg1[DATA_W-1] ^ reg2[DATA_W-1] ^ is_sub) &
                 (sum[DATA_W-1] ^ reg1[DATA_W-1]);
    assign slt = (reg1[DATA_W-1] & ~reg2[DATA_W-1]) |
                 (~(reg1[DATA_W-1] ^ reg2[DATA_W-1]) & sum[DATA_W-1]);

    // the low 64 bits of the extended product are the exact 32x32 product.
    assign is_signed_mul = (head_i.aluop == EXE_MULT_OP) || (head_i.aluop == EXE_MUL_OP);
    assign mul_a   = {{DATA_W{is_signed_mul & reg1[DATA_W-1]}}, reg1};
    assign mul_b   = {{DATA_W{is_signed_mul & reg2[DATA_W-1]}}, reg2};
    assign product = mul_a * mul_b;

    always_comb begin
        res_next.wd    = head_i.wd;
        res_next.wreg  = head_i.wreg;
        res_next.wdata = '0;
        hilo_next      = hilo_i;
        hilo_wr        = 1'b0;
        case (head_i.aluop)
            EXE_OR_OP:   res_next.wdata = reg1 | reg2;
            EXE_AND_OP:  res_next.wdata = reg1 & reg2;
            EXE_XOR_OP:  res_next.wdata = reg1 ^ reg2;
            EXE_NOR_OP:  res_next.wdata = ~(reg1 | reg2);
            EXE_SLL_OP:  res_next.wdata = reg2 << reg1[SHAMT_W-1:0];
            EXE_SRL_OP:  res_next.wdata = reg2 >> reg1[SHAMT_W-1:0];
            EXE_SRA_OP:  res_next.wdata = $signed(reg2) >>> reg1[SHAMT_W-1:0];
            EXE_ADDU_OP, EXE_SUBU_OP: res_next.wdata = sum;
            EXE_ADD_OP, EXE_SUB_OP: begin
                res_next.wdata = sum;
                res_next.wreg  = head_i.wreg & ~ovf;
            end
            EXE_SLT_OP:  res_next.wdata = {{(DATA_W-1){1'b0}}, slt};
            EXE_SLTU_OP: res_next.wdata = {{(DATA_W-1){1'b0}}, reg1 < reg2};
            EXE_CLZ_OP:  res_next.wdata = {{(DATA_W-CLZ_W){1'b0}}, lead_zeros(reg1)};
            EXE_CLO_OP:  res_next.wdata = {{(DATA_W-CLZ_W){1'b0}}, lead_zeros(~reg1)};
            EXE_MFHI_OP: res_next.wdata = hilo_i.hi;
            EXE_MFLO_OP: res_next.wdata = hilo_i.lo;
            EXE_MUL_OP:  res_next.wdata = product[DATA_W-1:0];
            EXE_MTHI_OP: begin
                hilo_next.hi = reg1;
                hilo_wr      = 1'b1;
            end
            EXE_MTLO_OP: begin
                hilo_next.lo = reg1;
                hilo_wr      = 1'b1;
            end
            EXE_MULT_OP, EXE_MULTU_OP: begin
                hilo_next = product;
                hilo_wr   = 1'b1;
            end
            default: res_next.wdata = '0;
        endcase
    end

    // the stage can take a new result when it is empty or drains this cycle.
    assign res_valid_o = res_valid_q & send_ok_i;
    assign pop_o       = head_valid_i & (~res_valid_q | res_valid_o);
    assign hilo_we_o   = hilo_wr & pop_o;
    assign hilo_o      = hilo_next;
    assign res_o       = res_q;

    always_ff @(posedge clk) begin
        if (pop_o) begin
            res_q <= res_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_valid_q <= 1'b0;
        end else if (pop_o) begin
            res_valid_q <= 1'b1;
        end else if (res_valid_o) begin
            res_valid_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/res_credit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module res_credit_counter
    import ex_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  credit_i,
    input  logic  send_i,
    output logic  send_ok_o
);

    logic [RES_CNT_W-1:0] credit_cnt;

    // a send and a returned credit in the same cycle cancel out.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            credit_cnt <= RES_CNT_W'(RES_CREDITS);
        end else begin
            case ({credit_i, send_i})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    assign send_ok_o = (credit_cnt != '0);

endmodule

`default_nettype wire

/* verilog/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import ex_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     op_valid_i,
    input  ex_op_t   op_i,
    output logic     op_credit_o,
    output logic     res_valid_o,
    output ex_res_t  res_o,
    input  logic     res_credit_i
);

    ex_op_t  head;
    logic    head_valid;
    logic    pop;
    hilo_t   hilo_cur;
    hilo_t   hilo_wr_data;
    logic    hilo_we;
    logic    send_ok;

    op_queue i_op_queue (
        .clk          (clk),
        .reset_i      (reset_i),
        .push_i       (op_valid_i),
        .op_i         (op_i),
        .pop_i        (pop),
        .head_o       (head),
        .head_valid_o (head_valid),
        .credit_o     (op_credit_o)
    );

    alu_core i_alu_core (
        .clk          (clk),
        .reset_i      (reset_i),
        .head_i       (head),
        .head_valid_i (head_valid),
        .pop_o        (pop),
        .hilo_i       (hilo_cur),
        .hilo_we_o    (hilo_we),
        .hilo_o       (hilo_wr_data),
        .send_ok_i    (send_ok),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o)
    );

    // HI/LO is written at the pop edge, so the next popped operation reads the new value.
    hilo_regs i_hilo_regs (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (hilo_we),
        .hilo_i   (hilo_wr_data),
        .hilo_o   (hilo_cur)
    );

    res_credit_counter i_res_credit_counter (
        .clk       (clk),
        .reset_i   (reset_i),
        .credit_i  (res_credit_i),
        .send_i    (res_valid_o),
        .send_ok_o (send_ok)
    );

endmodule

`default_nettype wire

/* verif/exec_unit_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit_assert
    import ex_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  res_valid_i,
    input  logic                  credit_i,
    input  logic [RES_CNT_W-1:0]  credit_cnt_i,
    input  logic                  push_i,
    input  logic [OP_CNT_W-1:0]   fill_cnt_i
);

    logic [RES_CNT_W-1:0] occupied;

    // results sitting in the downstream buffer, counted from the stream ports alone.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            occupied <= '0;
        end else if (res_valid_i && !credit_i) begin
            occupied <= occupied + 1'b1;
        end else if (credit_i && !res_valid_i) begin
            occupied <= occupied - 1'b1;
        end
    end

    // a result only leaves while downstream has a free slot.
    send_needs_credit: assert property (@(posedge clk) disable iff (reset_i)
        res_valid_i |-> (occupied < RES_CNT_W'(RES_CREDITS)))
        else $error("result sent while the downstream buffer was full");

    credit_bound: assert property (@(posedge clk) disable iff (reset_i)
        credit_cnt_i <= RES_CNT_W'(RES_CREDITS))
        else $error("result credit count above its reset value");

    // upstream holds no credit while every queue slot is taken.
    no_push_when_full: assert property (@(posedge clk) disable iff (reset_i)
        push_i |-> (fill_cnt_i != OP_CNT_W'(OP_CREDITS)))
        else $error("operation pushed into a full queue");

endmodule

bind exec_unit exec_unit_assert i_exec_unit_assert (
    .clk          (clk),
    .reset_i      (reset_i),
    .res_valid_i  (res_valid_o),
    .credit_i     (res_credit_i),
    .credit_cnt_i (i_res_credit_counter.credit_cnt),
    .push_i       (op_valid_i),
    .fill_cnt_i   (i_op_queue.fill_cnt)
);

`default_nettype wire

/* verif/tb_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit
    import ex_pkg::*;
();

    localparam int NUM_OPS        = 400;
    localparam int NUM_OPCODES    = 22;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 100;

    logic    clk = 1'b0;
    logic    reset_i;
    logic    op_valid_i;
    ex_op_t  op_i;
    logic    op_credit_o;
    logic    res_valid_o;
    ex_res_t res_o;
    logic    res_credit_i;

    logic [DATA_W-1:0] rng_state = 32'd51345;
    logic [DATA_W-1:0] model_hi;
    logic [DATA_W-1:0] model_lo;
    ex_res_t           exp_q[$];

    int up_credits;
    int held;
    int sent;
    int credit_pulses;
    int res_pulses;
    int credits_granted;
    int value_errors;
    int other_faults;

    exec_unit i_exec_unit (
        .clk          (clk),
        .reset_i      (reset_i),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .op_credit_o  (op_credit_o),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o),
        .res_credit_i (res_credit_i)
    );

    always #4 clk = ~clk;

    function automatic logic [DATA_W-1:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // edge values show up in about half of the operands.
    function automatic logic [DATA_W-1:0] pick_operand();
        case (next_rand() % 8)
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            default: return next_rand();
        endcase
    endfunction

    function automatic ex_op_t random_op();
        ex_op_t op;
        op.aluop = aluop_t'(5'(next_rand() % NUM_OPCODES));
        op.reg1  = pick_operand();
        op.reg2  = pick_operand();
        op.wd    = 5'(next_rand());
        op.wreg  = 1'(next_rand());
        return op;
    endfunction

    function automatic logic [DATA_W-1:0] count_leading(input logic [DATA_W-1:0] v,
                                                        input logic bit_val);
        logic [DATA_W-1:0] n;
        n = '0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (v[i] != bit_val) begin
                break;
            end
            n++;
        end
        return n;
    endfunction

    // the reference model runs in issue order, which is also the order HI/LO is updated in.
    task automatic model_accept(input ex_op_t op);
        ex_res_t           r;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] d;
        logic [63:0]       p;
        a = op.reg1;
        b = op.reg2;
        p = $unsigned(longint'($signed(a)) * longint'($signed(b)));
        r.wd    = op.wd;
        r.wreg  = op.wreg;
        r.wdata = '0;
        case (op.aluop)
            EXE_OR_OP:   r.wdata = a | b;
            EXE_AND_OP:  r.wdata = a & b;
            EXE_XOR_OP:  r.wdata = a ^ b;
            EXE_NOR_OP:  r.wdata = ~(a | b);
            EXE_SLL_OP:  r.wdata = b << a[4:0];
            EXE_SRL_OP:  r.wdata = b >> a[4:0];
            EXE_SRA_OP:  r.wdata = $signed(b) >>> a[4:0];
            EXE_ADDU_OP: r.wdata = a + b;
            EXE_SUBU_OP: r.wdata = a - b;
            EXE_ADD_OP: begin
                d = a + b;
                r.wdata = d;
                if (a[31] == b[31] && d[31] != a[31]) begin
                    r.wreg = 1'b0;
                end
            end
            EXE_SUB_OP: begin
                d = a - b;
                r.wdata = d;
                if (a[31] != b[31] && d[31] != a[31]) begin
                    r.wreg = 1'b0;
                end
            end
            EXE_SLT_OP:  r.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            EXE_SLTU_OP: r.wdata = (a < b) ? 32'd1 : 32'd0;
            EXE_CLZ_OP:  r.wdata = count_leading(a, 1'b0);
            EXE_CLO_OP:  r.wdata = count_leading(a, 1'b1);
            EXE_MFHI_OP: r.wdata = model_hi;
            EXE_MFLO_OP: r.wdata = model_lo;
            EXE_MTHI_OP: model_hi = a;
            EXE_MTLO_OP: model_lo = a;
            EXE_MULT_OP: begin
                model_hi = p[63:32];
                model_lo = p[31:0];
            end
            EXE_MULTU_OP: begin
                p = {32'd0, a} * {32'd0, b};
                model_hi = p[63:32];
                model_lo = p[31:0];
            end
            EXE_MUL_OP:  r.wdata = p[31:0];
            default:     r.wdata = '0;
        endcase
        exp_q.push_back(r);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("CHECK FAILED at %0t: %s expected 0x%0h got 0x%0h",
                 $time, name, expected, actual);
        value_errors++;
    endtask

    task automatic report_fault(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        other_faults++;
    endtask

    task automatic print_counts();
        $display("errors: %0d value mismatches, %0d other faults", value_errors, other_faults);
    endtask

    // outputs come from registers only, so they are stable at the falling edge.
    task automatic sample_outputs();
        ex_res_t exp;
        if (op_credit_o) begin
            credit_pulses++;
            up_credits++;
            if (up_credits > OP_CREDITS) begin
                report_fault("op_credit_o returned more credits than were spent");
            end
        end
        if (res_valid_o) begin
            res_pulses++;
            held++;
            if (res_pulses > credits_granted + RES_CREDITS) begin
                report_fault("res_valid_o fired without a free result slot");
            end
            if (exp_q.size() == 0) begin
                report_fault("res_valid_o fired with no operation outstanding");
            end else begin
                exp = exp_q.pop_front();
                if (res_o.wd !== exp.wd) begin
                    report_mismatch("res_o.wd", 64'(exp.wd), 64'(res_o.wd));
                end
                if (res_o.wreg !== exp.wreg) begin
                    report_mismatch("res_o.wreg", 64'(exp.wreg), 64'(res_o.wreg));
                end
                if (res_o.wdata !== exp.wdata) begin
                    report_mismatch("res_o.wdata", 64'(exp.wdata), 64'(res_o.wdata));
                end
            end
        end
    endtask

    // result credits come back slowly at first and faster as the run goes on.
    task automatic drive_inputs();
        ex_op_t op;
        int     ret_level;
        op_valid_i   = 1'b0;
        res_credit_i = 1'b0;
        if (up_credits > 0 && sent < NUM_OPS && (next_rand() % 4) != 0) begin
            op = random_op();
            op_i       = op;
            op_valid_i = 1'b1;
            up_credits--;
            sent++;
            model_accept(op);
        end
        ret_level = 1 + 2 * (sent / 100);
        if (held > 0 && int'(next_rand() % 8) < ret_level) begin
            res_credit_i = 1'b1;
            held--;
            credits_granted++;
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        report_fault($sformatf("the run did not finish within %0d cycles", TIMEOUT_CYCLES));
        print_counts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        reset_i         = 1'b1;
        op_valid_i      = 1'b0;
        op_i            = '0;
        res_credit_i    = 1'b0;
        model_hi        = '0;
        model_lo        = '0;
        up_credits      = OP_CREDITS;
        held            = 0;
        sent            = 0;
        credit_pulses   = 0;
        res_pulses      = 0;
        credits_granted = 0;
        value_errors    = 0;
        other_faults    = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);
        if (res_valid_o !== 1'b0) begin
            report_mismatch("res_valid_o after reset", 64'd0, 64'(res_valid_o));
        end
        if (op_credit_o !== 1'b0) begin
            report_mismatch("op_credit_o after reset", 64'd0, 64'(op_credit_o));
        end
        while (sent < NUM_OPS || exp_q.size() != 0) begin
            sample_outputs();
            drive_inputs();
            @(negedge clk);
        end
        // a few idle cycles catch late duplicates or stray credit pulses.
        repeat (20) begin
            sample_outputs();
            drive_inputs();
            @(negedge clk);
        end
        if (credit_pulses != sent) begin
            report_mismatch("op_credit_o pulse count", 64'(sent), 64'(credit_pulses));
        end
        if (res_pulses != NUM_OPS) begin
            report_mismatch("res_valid_o pulse count", 64'(NUM_OPS), 64'(res_pulses));
        end
        print_counts();
        if (value_errors == 0 && other_faults == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/ex_pkg.sv
verilog/op_queue.sv
verilog/hilo_regs.sv
verilog/alu_core.sv
verilog/res_credit_counter.sv
verilog/exec_unit.sv
verif/exec_unit_assert.sv
verif/tb_exec_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the exec_unit testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_unit \
        -f src.f -o sim_exec_unit; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_exec_unit > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0
